/* rtl/pixel_upload_pkg.sv */
// Pixel uploader shared definitions
`default_nettype none

package pixel_upload_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    localparam int avl_addr_w       = 33;
    localparam int beat_bytes       = 32;
    localparam int beat_w           = beat_bytes * 8;     // one line beat
    localparam int pixel_w          = 32;
    localparam int words_plain      = beat_w / pixel_w;   // 8 words without repack
    localparam int words_packed     = (beat_w * 3 / 4) / pixel_w;  // 6 words of 3-byte pixels
    localparam int word_idx_w       = $clog2(words_plain);
    localparam int line_fifo_depth  = 2;
    localparam int pixel_fifo_depth = 16;
    localparam int credit_w         = $clog2(pixel_fifo_depth + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Avalon-MM read-only master
    typedef struct packed {
        logic [avl_addr_w-1:0] address;
        logic                  read;
    } avl_cmd_t;

    typedef struct packed {
        logic [beat_w-1:0] readdata;
        logic              readdatavalid;
        logic [1:0]        response;     // 0 is OKAY
        logic              waitrequest;
    } avl_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal payloads
    typedef struct packed {
        logic [beat_w-1:0] data;
        logic              transform;    // repack mode taken with the read
    } line_beat_t;

    typedef struct packed {
        logic [pixel_w-1:0] data;
    } pixel_word_t;

    // state encodings
    typedef enum logic [1:0] {IDLE, FETCH, HALT} fetch_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT} rd_state_t;

endpackage

`default_nettype wire

/* rtl/pixel_fetch_ctrl.sv */
// Pixel fetch controller
`default_nettype none

module pixel_fetch_ctrl (
    input  wire         clk,
    input  wire         reset_current_address,
    input  wire         enable,
    input  wire         word_mode,            // 1 = word addressing, 0 = byte addressing
    input  wire  [31:0] base_address,
    input  wire  [31:0] total_size,
    input  wire         reader_busy,
    input  wire         beat_done,
    input  wire         beat_error,
    input  wire         line_credit_return,
    output logic        fetch_valid,
    output logic [pixel_upload_pkg::avl_addr_w-1:0] fetch_addr,
    output logic        active,
    output logic        read_error
);

    pixel_upload_pkg::fetch_state_t state;

    logic        enable_q;
    logic        enable_rise;
    logic [31:0] base_q;
    logic [31:0] cur_addr;
    logic [31:0] next_addr;
    logic        beat_ok;
    logic        beat_fail;
    logic [pixel_upload_pkg::credit_w-1:0] credits;

    assign enable_rise = enable & ~enable_q;
    assign beat_ok     = beat_done & ~beat_error;
    assign beat_fail   = beat_done & beat_error;
    assign next_addr   = cur_addr + (word_mode ? 32'd8 : 32'd32);  // one beat either way

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine and sticky error
    always_ff @(posedge clk)
    begin
        if (reset_current_address)
        begin
            state      <= pixel_upload_pkg::IDLE;
            enable_q   <= 1'b0;
            read_error <= 1'b0;
        end
        else
        begin
            enable_q <= enable;
            case (state)
                pixel_upload_pkg::IDLE:
                    if (enable_rise)
                        state <= pixel_upload_pkg::FETCH;
                pixel_upload_pkg::FETCH:
                    if (beat_fail)
                    begin
                        state      <= pixel_upload_pkg::HALT;
                        read_error <= 1'b1;
                    end
                    else if (!enable && !reader_busy)
                        state <= pixel_upload_pkg::IDLE;   // let the open read finish
                pixel_upload_pkg::HALT:
                    if (!enable)
                    begin
                        state      <= pixel_upload_pkg::IDLE;
                        read_error <= 1'b0;
                    end
                default:
                    state <= pixel_upload_pkg::IDLE;
            endcase
        end
    end

    // address walk with wrap to the latched base at the frame end
    always_ff @(posedge clk)
    begin
        if (state == pixel_upload_pkg::IDLE && enable_rise)
        begin
            base_q   <= base_address;
            cur_addr <= base_address;
        end
        else if (beat_ok)
            cur_addr <= (next_addr == base_q + total_size) ? base_q : next_addr;
    end

    // one line credit per free line buffer slot
    always_ff @(posedge clk)
    begin
        if (reset_current_address)
            credits <= pixel_upload_pkg::credit_w'(pixel_upload_pkg::line_fifo_depth);
        else
            credits <= credits + pixel_upload_pkg::credit_w'(line_credit_return)
                     + pixel_upload_pkg::credit_w'(beat_fail)   // nothing pushed on error
                     - pixel_upload_pkg::credit_w'(fetch_valid);
    end

    assign fetch_valid = (state == pixel_upload_pkg::FETCH) && enable && !reader_busy
                       && (credits != '0);
    assign fetch_addr  = pixel_upload_pkg::avl_addr_w'(cur_addr);
    assign active      = (state == pixel_upload_pkg::FETCH);

    a_line_credit_max: assert property (@(posedge clk) disable iff (reset_current_address)
        credits <= pixel_upload_pkg::credit_w'(pixel_upload_pkg::line_fifo_depth));

endmodule

`default_nettype wire

/* rtl/avalon_read_master.sv */
// Avalon-MM single read master
`default_nettype none

module avalon_read_master (
    input  wire                               clk,
    input  wire                               reset_current_address,
    input  wire                               fetch_valid,
    input  wire [pixel_upload_pkg::avl_addr_w-1:0] fetch_addr,
    input  wire                               transform_data,
    input  wire pixel_upload_pkg::avl_rsp_t   avl_rsp,
    output pixel_upload_pkg::avl_cmd_t        avl_cmd,
    output logic                              reader_busy,
    output logic                              beat_done,
    output logic                              beat_error,
    output logic                              line_push,
    output pixel_upload_pkg::line_beat_t      line_beat
);

    pixel_upload_pkg::rd_state_t state;

    logic [pixel_upload_pkg::avl_addr_w-1:0] addr_q;
    logic transform_q;

    always_ff @(posedge clk)
    begin
        if (reset_current_address)
            state <= pixel_upload_pkg::RD_IDLE;
        else
            case (state)
                pixel_upload_pkg::RD_IDLE:
                    if (fetch_valid)
                        state <= pixel_upload_pkg::RD_REQ;
                pixel_upload_pkg::RD_REQ:
                    if (!avl_rsp.waitrequest)
                        state <= pixel_upload_pkg::RD_WAIT;   // command accepted
                pixel_upload_pkg::RD_WAIT:
                    if (avl_rsp.readdatavalid)
                        state <= pixel_upload_pkg::RD_IDLE;
                default:
                    state <= pixel_upload_pkg::RD_IDLE;
            endcase
    end

    // request fields held until the response
    always_ff @(posedge clk)
    begin
        if (state == pixel_upload_pkg::RD_IDLE && fetch_valid)
        begin
            addr_q      <= fetch_addr;
            transform_q <= transform_data;
        end
    end

    assign avl_cmd     = '{address: addr_q, read: (state == pixel_upload_pkg::RD_REQ)};
    assign reader_busy = (state != pixel_upload_pkg::RD_IDLE);

    assign beat_done  = (state == pixel_upload_pkg::RD_WAIT) && avl_rsp.readdatavalid;
    assign beat_error = |avl_rsp.response;
    assign line_push  = beat_done && !beat_error;
    assign line_beat  = '{data: avl_rsp.readdata, transform: transform_q};

    // the slave answers only an accepted read
    a_rsp_when_open: assert property (@(posedge clk) disable iff (reset_current_address)
        avl_rsp.readdatavalid |-> state == pixel_upload_pkg::RD_WAIT);

endmodule

`default_nettype wire

/* rtl/credit_fifo.sv */
// Credit-returning FIFO
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 2
) (
    input  wire      clk,
    input  wire      reset_current_address,
    input  wire      push,
    input  wire payload_t push_data,
    input  wire      pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit_return
);

    payload_t mem [depth];

    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] mem_cnt;     // entries behind the output word
    logic out_valid;
    logic load_out;
    logic take_mem;
    logic bypass;
    logic put_mem;

    assign load_out = !out_valid || pop;
    assign take_mem = load_out && (mem_cnt != '0);
    assign bypass   = load_out && (mem_cnt == '0) && push;  // empty FIFO sends push to output
    assign put_mem  = push && !bypass;

    always_ff @(posedge clk)
    begin
        if (reset_current_address)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_cnt   <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (put_mem)
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            if (take_mem)
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            mem_cnt <= mem_cnt + put_mem - take_mem;
            if (load_out)
                out_valid <= take_mem || bypass;
        end
    end

    always_ff @(posedge clk)
    begin
        if (put_mem)
            mem[wr_ptr] <= push_data;
        if (take_mem)
            pop_data <= mem[rd_ptr];
        else if (bypass)
            pop_data <= push_data;
    end

    assign not_empty     = out_valid;
    assign credit_return = pop;        // producer may reuse the freed slot next cycle

    a_no_push_full: assert property (@(posedge clk) disable iff (reset_current_address)
        push |-> (int'(mem_cnt) + int'(out_valid)) < depth);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_current_address)
        pop |-> out_valid);

endmodule

`default_nettype wire

/* rtl/pixel_repacker.sv */
// Line beat to pixel word repacker
`default_nettype none

module pixel_repacker (
    input  wire                                clk,
    input  wire                                reset_current_address,
    input  wire                                line_not_empty,
    input  wire pixel_upload_pkg::line_beat_t  line_beat,
    input  wire                                pix_credit_return,
    output logic                               line_pop,
    output logic                               pix_push,
    output pixel_upload_pkg::pixel_word_t      pix_word
);

    pixel_upload_pkg::line_beat_t beat_q;

    logic busy;
    logic last_word;
    logic [pixel_upload_pkg::word_idx_w-1:0] idx;
    logic [pixel_upload_pkg::credit_w-1:0]   credits;
    logic [pixel_upload_pkg::words_packed*pixel_upload_pkg::pixel_w-1:0] packed_vec;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 4-byte to 3-byte pixels by dropping byte 3 of each pixel
    for (genvar i = 0; i < pixel_upload_pkg::beat_bytes; i++)
    begin : g_byte
        if (i % 4 != 3)
        begin : g_keep
            assign packed_vec[((i / 4) * 3 + i % 4) * 8 +: 8] = beat_q.data[i * 8 +: 8];
        end
    end

    assign line_pop  = !busy && line_not_empty;
    assign pix_push  = busy && (credits != '0);
    assign last_word = beat_q.transform
                     ? (idx == pixel_upload_pkg::word_idx_w'(pixel_upload_pkg::words_packed - 1))
                     : (idx == pixel_upload_pkg::word_idx_w'(pixel_upload_pkg::words_plain - 1));

    // lowest word first
    assign pix_word.data = beat_q.transform
                         ? packed_vec[idx * pixel_upload_pkg::pixel_w +: pixel_upload_pkg::pixel_w]
                         : beat_q.data[idx * pixel_upload_pkg::pixel_w +: pixel_upload_pkg::pixel_w];

    always_ff @(posedge clk)
    begin
        if (reset_current_address)
        begin
            busy    <= 1'b0;
            idx     <= '0;
            credits <= pixel_upload_pkg::credit_w'(pixel_upload_pkg::pixel_fifo_depth);
        end
        else
        begin
            if (line_pop)
            begin
                busy <= 1'b1;
                idx  <= '0;
            end
            else if (pix_push)
            begin
                if (last_word)
                    busy <= 1'b0;     // beat finished
                idx <= idx + 1'b1;
            end
            credits <= credits + pixel_upload_pkg::credit_w'(pix_credit_return)
                     - pixel_upload_pkg::credit_w'(pix_push);
        end
    end

    always_ff @(posedge clk)
    begin
        if (line_pop)
            beat_q <= line_beat;
    end

    a_pix_credit_max: assert property (@(posedge clk) disable iff (reset_current_address)
        credits <= pixel_upload_pkg::credit_w'(pixel_upload_pkg::pixel_fifo_depth));

endmodule

`default_nettype wire

/* rtl/pixel_uploader_top.sv */
// Pixel uploader top level
`default_nettype none

module pixel_uploader_top (
    input  wire                                clk,
    input  wire                                reset_current_address,
    input  wire                                enable,
    input  wire                                word_mode,
    input  wire                                transform_data,
    input  wire  [31:0]                        base_address,
    input  wire  [31:0]                        total_size,
    input  wire pixel_upload_pkg::avl_rsp_t    avl_rsp,
    input  wire                                pix_ready,
    output pixel_upload_pkg::avl_cmd_t         avl_cmd,
    output pixel_upload_pkg::pixel_word_t      pix_out,
    output logic                               pix_valid,
    output logic                               active,
    output logic                               read_error
);

    logic fetch_valid;
    logic [pixel_upload_pkg::avl_addr_w-1:0] fetch_addr;
    logic reader_busy;
    logic beat_done;
    logic beat_error;

    // line path
    logic line_push;
    logic line_pop;
    logic line_not_empty;
    logic line_credit_return;
    pixel_upload_pkg::line_beat_t line_beat_in;
    pixel_upload_pkg::line_beat_t line_beat_out;

    // pixel path
    logic pix_push;
    logic pix_credit_return;
    pixel_upload_pkg::pixel_word_t pix_word;

    pixel_fetch_ctrl ctrl_i (
        .clk, .reset_current_address, .enable, .word_mode, .base_address, .total_size,
        .reader_busy, .beat_done, .beat_error, .line_credit_return,
        .fetch_valid, .fetch_addr, .active, .read_error
    );

    avalon_read_master reader_i (
        .clk, .reset_current_address, .fetch_valid, .fetch_addr, .transform_data,
        .avl_rsp, .avl_cmd, .reader_busy, .beat_done, .beat_error, .line_push,
        .line_beat (line_beat_in)
    );

    credit_fifo #(
        .payload_t (pixel_upload_pkg::line_beat_t),
        .depth     (pixel_upload_pkg::line_fifo_depth)
    ) line_buffer_i (
        .clk, .reset_current_address,
        .push (line_push), .push_data (line_beat_in), .pop (line_pop),
        .pop_data (line_beat_out), .not_empty (line_not_empty),
        .credit_return (line_credit_return)
    );

    pixel_repacker repacker_i (
        .clk, .reset_current_address, .line_not_empty,
        .line_beat (line_beat_out), .pix_credit_return,
        .line_pop, .pix_push, .pix_word
    );

    credit_fifo #(
        .payload_t (pixel_upload_pkg::pixel_word_t),
        .depth     (pixel_upload_pkg::pixel_fifo_depth)
    ) pixel_fifo_i (
        .clk, .reset_current_address,
        .push (pix_push), .push_data (pix_word), .pop (pix_valid && pix_ready),
        .pop_data (pix_out), .not_empty (pix_valid),
        .credit_return (pix_credit_return)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock source
`default_nettype none

module tb_clock_gen #(
    parameter int period = 20
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

/* testbench/pixel_uploader_tb.sv */
// Pixel uploader testbench
`default_nettype none

module pixel_uploader_tb;

    // words the five behaviors ask for plus one pipeline of drain slack per run
    localparam int planned_words   = 80 + 60 + 112 + 96 + 24 + 48;
    localparam int drain_words     = 6 * 40;
    localparam int watchdog_cycles = (planned_words + drain_words) * 40 + 2000;
    localparam int max_in_flight   = 40;   // two line credits, beat in repacker, full pixel FIFO

    logic        clk;
    logic        reset_current_address;
    logic        enable;
    logic        word_mode;
    logic        transform_data;
    logic [31:0] base_address;
    logic [31:0] total_size;
    logic        pix_ready = 1'b0;
    logic        pix_valid;
    logic        active;
    logic        read_error;
    pixel_upload_pkg::avl_rsp_t    avl_rsp = '0;
    pixel_upload_pkg::avl_cmd_t    avl_cmd;
    pixel_upload_pkg::pixel_word_t pix_out;

    // reference model state
    logic [31:0] exp_q [$];
    logic [31:0] exp_addr;
    logic [31:0] exp_base;
    logic [31:0] exp_size;
    logic [31:0] exp_step;
    logic        exp_xform;
    logic [31:0] err_addr;
    logic        err_on;
    logic        err_seen;
    logic        sink_slow;
    int          rcv_count;
    int          value_errors;
    int          protocol_errors;

    // memory model state
    logic [31:0] lfsr_state = 32'h5cb8_99e3;
    logic        pending;
    logic [32:0] pend_addr;
    int          lat_cnt;

    tb_clock_gen #(.period(20)) clock_i (.clk);

    pixel_uploader_top dut_i (
        .clk, .reset_current_address, .enable, .word_mode, .transform_data,
        .base_address, .total_size, .avl_rsp, .pix_ready,
        .avl_cmd, .pix_out, .pix_valid, .active, .read_error
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source and memory contents
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_step()};   // one step per bit
        return r;
    endfunction

    function automatic logic [255:0] beat_data(input logic [32:0] addr);
        logic [255:0] beat;
        logic [31:0]  h;
        for (int j = 0; j < 32; j++)
        begin
            h = (addr[31:0] ^ {31'd0, addr[32]}) * 32'h9e37_79b1 + j * 32'h85eb_ca6b;
            beat[j*8 +: 8] = h[31:24] ^ h[15:8];
        end
        return beat;
    endfunction

    // pixel words of one beat with byte 0 lowest
    task automatic push_expected(input logic [255:0] beat, input logic xform);
        logic [191:0] kept;
        int           n;
        n = 0;
        if (xform)
        begin
            for (int j = 0; j < 32; j++)
            begin
                if (j % 4 != 3)
                begin
                    kept[n*8 +: 8] = beat[j*8 +: 8];
                    n++;
                end
            end
            for (int k = 0; k < 6; k++)
                exp_q.push_back(kept[k*32 +: 32]);
        end
        else
            for (int k = 0; k < 8; k++)
                exp_q.push_back(beat[k*32 +: 32]);
    endtask

    task automatic check_read_accept(input logic [32:0] addr);
        logic [31:0] next;
        assert (addr == {1'b0, exp_addr})
        else
        begin
            value_errors++;
            $display("ERROR @%0t: read address %h, expected %h", $time, addr, exp_addr);
        end
        if (err_on && exp_addr == err_addr)
            err_seen = 1'b1;          // error beat gives no words
        else
        begin
            push_expected(beat_data({1'b0, exp_addr}), exp_xform);
            next     = exp_addr + exp_step;
            exp_addr = (next == exp_base + exp_size) ? exp_base : next;
        end
        assert (exp_q.size() <= max_in_flight)
        else
        begin
            protocol_errors++;
            $display("ERROR @%0t: %0d words in flight, buffers hold at most %0d",
                     $time, exp_q.size(), max_in_flight);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Avalon memory and pixel sink
    always @(posedge clk)
    begin : avalon_memory
        pixel_upload_pkg::avl_rsp_t rsp;
        if (reset_current_address)
        begin
            avl_rsp   <= '0;
            pix_ready <= 1'b0;
            pending = 1'b0;
        end
        else
        begin
            pix_ready <= sink_slow ? (rand_bits(2) == 32'd3) : 1'b1;
            if (avl_cmd.read && (pending || avl_rsp.readdatavalid))
            begin
                protocol_errors++;
                $display("ERROR @%0t: second read issued while one is outstanding", $time);
            end
            if (avl_cmd.read && err_seen)
            begin
                protocol_errors++;
                $display("ERROR @%0t: read issued after a read error", $time);
            end
            rsp = '0;
            rsp.waitrequest = rand_bits(1);
            if (avl_cmd.read && !avl_rsp.waitrequest)
            begin
                check_read_accept(avl_cmd.address);
                pending   = 1'b1;
                pend_addr = avl_cmd.address;
                lat_cnt   = int'(rand_bits(2));   // 1 to 4 cycles to readdatavalid
            end
            if (pending)
            begin
                if (lat_cnt == 0)
                begin
                    rsp.readdatavalid = 1'b1;
                    rsp.readdata      = beat_data(pend_addr);
                    rsp.response      = (err_on && pend_addr[31:0] == err_addr) ? 2'd2 : 2'd0;
                    pending = 1'b0;
                end
                else
                    lat_cnt--;
            end
            avl_rsp <= rsp;
        end
    end

    always @(posedge clk)
    begin : pixel_check
        logic [31:0] want;
        if (!reset_current_address && pix_valid && pix_ready)
        begin
            if (exp_q.size() == 0)
            begin
                protocol_errors++;
                $display("ERROR @%0t: pixel word %h arrived with none expected",
                         $time, pix_out.data);
            end
            else
            begin
                want = exp_q.pop_front();
                assert (pix_out.data == want)
                else
                begin
                    value_errors++;
                    $display("ERROR @%0t: pixel word %h, expected %h", $time, pix_out.data, want);
                end
            end
            rcv_count++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    task automatic start_stream(input logic [31:0] base, input logic [31:0] size,
                                input logic wmode, input logic xform, input logic slow);
        @(posedge clk);
        base_address   <= base;
        total_size     <= size;
        word_mode      <= wmode;
        transform_data <= xform;
        sink_slow      <= slow;
        exp_base  = base;
        exp_size  = size;
        exp_addr  = base;
        exp_step  = wmode ? 32'd8 : 32'd32;
        exp_xform = xform;
        @(posedge clk);
        enable <= 1'b1;
    endtask

    task automatic stop_stream();
        @(posedge clk);
        enable <= 1'b0;
        do
            @(negedge clk);
        while (active || exp_q.size() != 0);   // open read and buffered beats drain
    endtask

    task automatic run_stream(input logic [31:0] base, input logic [31:0] size,
                              input logic wmode, input logic xform, input logic slow,
                              input int words);
        int start;
        start = rcv_count;
        start_stream(base, size, wmode, xform, slow);
        do
            @(negedge clk);
        while (rcv_count < start + words);
        assert (active)
        else
        begin
            protocol_errors++;
            $display("ERROR @%0t: active low while the stream runs", $time);
        end
        stop_stream();
    endtask

    task automatic run_error_case();
        int start;
        start    = rcv_count;
        err_addr = 32'h2060;          // fourth beat of the frame
        err_on  <= 1'b1;
        start_stream(32'h2000, 32'd256, 1'b0, 1'b0, 1'b0);
        do
            @(negedge clk);
        while (!read_error);
        repeat (50) @(negedge clk);
        assert (exp_q.size() == 0 && rcv_count - start == 24 && !active)
        else
        begin
            protocol_errors++;
            $display("ERROR @%0t: %0d words before the read error, expected 24",
                     $time, rcv_count - start);
        end
        @(posedge clk);
        enable <= 1'b0;
        repeat (2) @(negedge clk);
        assert (!read_error)
        else
        begin
            protocol_errors++;
            $display("ERROR @%0t: read_error still set after enable fell", $time);
        end
        @(posedge clk);
        err_on <= 1'b0;
        err_seen = 1'b0;
        run_stream(32'h3000, 32'd128, 1'b0, 1'b0, 1'b0, 48);   // fresh base after the halt
    endtask

    task automatic end_run(input logic timed_out);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (!timed_out && value_errors == 0 && protocol_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    initial
    begin
        reset_current_address <= 1'b1;
        enable         <= 1'b0;
        word_mode      <= 1'b0;
        transform_data <= 1'b0;
        base_address   <= '0;
        total_size     <= '0;
        sink_slow      <= 1'b0;
        err_on         <= 1'b0;
        err_seen  = 1'b0;
        rcv_count = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (16) @(posedge clk);
        reset_current_address <= 1'b0;
        @(negedge clk);
        assert (!avl_cmd.read && !pix_valid && !active && !read_error)
        else
        begin
            protocol_errors++;
            $display("ERROR @%0t: outputs not idle after reset", $time);
        end
        run_stream(32'h1000, 32'd160, 1'b0, 1'b0, 1'b0, 80);   // plain data wrapping every 5 beats
        run_stream(32'h1800, 32'd256, 1'b0, 1'b1, 1'b0, 60);   // 3-byte repack
        run_stream(32'h0400, 32'd32, 1'b1, 1'b0, 1'b0, 112);   // word mode over 3.5 frames
        run_stream(32'h5000, 32'd192, 1'b0, 1'b0, 1'b1, 96);   // slow sink
        run_error_case();
        end_run(1'b0);
    end

    initial
    begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped delivering pixel words",
                 watchdog_cycles);
        end_run(1'b1);
    end

endmodule

`default_nettype wire

/* pixel_uploader.f */
rtl/pixel_upload_pkg.sv
rtl/pixel_fetch_ctrl.sv
rtl/avalon_read_master.sv
rtl/credit_fifo.sv
rtl/pixel_repacker.sv
rtl/pixel_uploader_top.sv
testbench/tb_clock_gen.sv
testbench/pixel_uploader_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pixel uploader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pixel_uploader_tb \
    -f pixel_uploader.f \
    -Mdir obj_dir -o pixel_uploader_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/pixel_uploader_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
